//--- hw/core_ctrl.sv
`include "core_cfg.svh"

module core_ctrl
	import core_pkg::*;
(
	input  logic     clock,
	input  logic     rst_n,
	mem_req_if.ctrl  mem,
	input  decoded_t dec,
	output word_t    inst,
	output word_t    pc,
	input  word_t    exu_val,
	input  word_t    jump,
	input  logic     jump_en,
	input  word_t    src2,
	output logic     rf_wen,
	output reg_idx_t rf_waddr,
	output word_t    rf_wdata,
	output logic     retire,
	output word_t    retire_pc
);

	typedef enum logic [2:0] {S_FETCH, S_IFWAIT, S_EXEC, S_MEM, S_WB} state_t;

	state_t state;
	word_t  pc_q;
	word_t  inst_q;
	word_t  ld_q;
	logic   err_q;
	logic   is_mem;
	word_t  next_pc;

	assign is_mem = (dec.kind == INST_LW) || (dec.kind == INST_SW);
	assign next_pc = err_q ? `TRAP_PC : (jump_en ? jump : pc_q + 32'd4);

	// ##################################################
	// instruction cycle
	// ##################################################
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= S_FETCH;
			pc_q  <= `RESET_PC;
			err_q <= 1'b0;
		end else begin
			case (state)
				S_FETCH: state <= S_IFWAIT;
				S_IFWAIT: if (mem.done) begin
					err_q <= mem.err;
					state <= mem.err ? S_WB : S_EXEC; // bad fetch retires as-is.
				end
				S_EXEC: state <= is_mem ? S_MEM : S_WB;
				S_MEM: if (mem.done) begin
					err_q <= mem.err;
					state <= S_WB;
				end
				S_WB: begin
					pc_q  <= next_pc;
					err_q <= 1'b0;
					state <= S_FETCH;
				end
				default: state <= S_FETCH;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == S_IFWAIT && mem.done) inst_q <= mem.rdata;
		if (state == S_MEM && mem.done) ld_q <= mem.rdata;
	end

	assign mem.start = (state == S_FETCH) || (state == S_EXEC && is_mem);
	assign mem.write = (state == S_EXEC) && (dec.kind == INST_SW);
	assign mem.addr  = (state == S_FETCH) ? pc_q : exu_val; // effective address from exu.
	assign mem.wdata = src2;
	assign mem.wstrb = 4'hf;

	assign inst      = inst_q;
	assign pc        = pc_q;
	assign rf_wen    = (state == S_WB) && dec.reg_wen && !err_q;
	assign rf_waddr  = dec.rd;
	assign rf_wdata  = (dec.kind == INST_LW) ? ld_q : exu_val;
	assign retire    = (state == S_WB);
	assign retire_pc = pc_q;

endmodule

//--- hw/core_pkg.sv
`include "core_cfg.svh"

package core_pkg;

	typedef logic [`XLEN-1:0] word_t;
	typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
	typedef logic [1:0] resp_t; // zero is okay.

	// ##################################################
	// instruction kinds
	// ##################################################
	typedef enum logic [3:0] {
		INST_ILLEGAL,
		INST_LUI,
		INST_AUIPC,
		INST_JAL,
		INST_JALR,
		INST_BEQ,
		INST_LW,
		INST_SW,
		INST_ADDI,
		INST_ADD
	} inst_kind_t;

	// ##################################################
	// decoder output
	// ##################################################
	typedef struct packed {
		inst_kind_t kind;
		reg_idx_t   rd;
		reg_idx_t   rs1;
		reg_idx_t   rs2;
		word_t      imm; // sign extended.
		logic       reg_wen;
	} decoded_t;

endpackage

//--- hw/core_top.sv
module core_top
	import core_pkg::*;
(
	input  logic       clock,
	input  logic       rst_n,

	output word_t      araddr,
	output logic       arvalid,
	input  logic       arready,

	input  word_t      rdata,
	input  resp_t      rresp,
	input  logic       rvalid,
	output logic       rready,

	output word_t      awaddr,
	output logic       awvalid,
	input  logic       awready,

	output word_t      wdata,
	output logic [3:0] wstrb,
	output logic       wvalid,
	input  logic       wready,

	input  resp_t      bresp,
	input  logic       bvalid,
	output logic       bready,

	output logic       retire, // one pulse per instruction.
	output word_t      retire_pc
);

	decoded_t dec;
	word_t    inst;
	word_t    pc;
	word_t    src1;
	word_t    src2;
	word_t    exu_val;
	word_t    jump;
	logic     jump_en;
	logic     rf_wen;
	reg_idx_t rf_waddr;
	word_t    rf_wdata;

	mem_req_if mem_bus ();

	core_ctrl u_ctrl (
		.clock(clock), .rst_n(rst_n), .mem(mem_bus.ctrl),
		.dec(dec), .inst(inst), .pc(pc),
		.exu_val(exu_val), .jump(jump), .jump_en(jump_en), .src2(src2),
		.rf_wen(rf_wen), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
		.retire(retire), .retire_pc(retire_pc)
	);

	idu u_idu (.inst(inst), .dec(dec));

	exu u_exu (
		.dec(dec), .pc(pc), .src1(src1), .src2(src2),
		.val(exu_val), .jump(jump), .jump_en(jump_en)
	);

	regfile u_rf (
		.clock(clock), .rst_n(rst_n),
		.raddr1(dec.rs1), .raddr2(dec.rs2), .rdata1(src1), .rdata2(src2),
		.wen(rf_wen), .waddr(rf_waddr), .wdata(rf_wdata)
	);

	mem_access u_mem (
		.clock(clock), .rst_n(rst_n), .req(mem_bus.port),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready)
	);

endmodule

//--- hw/exu.sv
module exu
	import core_pkg::*;
(
	input  decoded_t dec,
	input  word_t    pc,
	input  word_t    src1,
	input  word_t    src2,
	output word_t    val,
	output word_t    jump,
	output logic     jump_en
);

	word_t sum;
	word_t pc_imm;
	word_t link;

	// one adder for add, addi and the effective address.
	assign sum    = src1 + ((dec.kind == INST_ADD) ? src2 : dec.imm);
	assign pc_imm = pc + dec.imm;
	assign link   = pc + 32'd4;

	always_comb begin
		case (dec.kind)
			INST_ADD,
			INST_ADDI,
			INST_LW,
			INST_SW:    val = sum;
			INST_LUI:   val = dec.imm;
			INST_AUIPC: val = pc_imm;
			INST_JAL,
			INST_JALR:  val = link;
			default:    val = '0;
		endcase
	end

	always_comb begin
		jump    = pc_imm;
		jump_en = 1'b0;
		case (dec.kind)
			INST_JAL: jump_en = 1'b1;
			INST_JALR: begin
				jump    = {sum[31:1], 1'b0}; // bit 0 cleared.
				jump_en = 1'b1;
			end
			INST_BEQ: jump_en = (src1 == src2);
			default: jump_en = 1'b0;
		endcase
	end

endmodule

//--- hw/idu.sv
module idu
	import core_pkg::*;
(
	input  word_t    inst,
	output decoded_t dec
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_s;
	word_t      imm_b;
	word_t      imm_u;
	word_t      imm_j;
	logic       writes_rd;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		dec.kind = INST_ILLEGAL;
		dec.imm  = imm_i;
		case (opcode)
			7'b0110111: begin dec.kind = INST_LUI;   dec.imm = imm_u; end
			7'b0010111: begin dec.kind = INST_AUIPC; dec.imm = imm_u; end
			7'b1101111: begin dec.kind = INST_JAL;   dec.imm = imm_j; end
			7'b1100111: if (funct3 == 3'b000) dec.kind = INST_JALR;
			7'b1100011: if (funct3 == 3'b000) begin
				dec.kind = INST_BEQ;
				dec.imm  = imm_b;
			end
			7'b0000011: if (funct3 == 3'b010) dec.kind = INST_LW;
			7'b0100011: if (funct3 == 3'b010) begin
				dec.kind = INST_SW;
				dec.imm  = imm_s;
			end
			7'b0010011: if (funct3 == 3'b000) dec.kind = INST_ADDI;
			7'b0110011: if (funct3 == 3'b000 && funct7 == 7'b0) dec.kind = INST_ADD;
			default: dec.kind = INST_ILLEGAL;
		endcase
	end

	// upper index bit dropped for rv32e.
	assign dec.rd  = inst[7 +: $bits(reg_idx_t)];
	assign dec.rs1 = inst[15 +: $bits(reg_idx_t)];
	assign dec.rs2 = inst[20 +: $bits(reg_idx_t)];

	assign writes_rd = (dec.kind == INST_LUI) || (dec.kind == INST_AUIPC) ||
		(dec.kind == INST_JAL) || (dec.kind == INST_JALR) ||
		(dec.kind == INST_LW) || (dec.kind == INST_ADDI) || (dec.kind == INST_ADD);
	assign dec.reg_wen = writes_rd && (dec.rd != '0);

endmodule

//--- hw/mem_access.sv
module mem_access
	import core_pkg::*;
(
	input  logic       clock,
	input  logic       rst_n,
	mem_req_if.port    req,
	output word_t      araddr,
	output logic       arvalid,
	input  logic       arready,
	input  word_t      rdata,
	input  resp_t      rresp,
	input  logic       rvalid,
	output logic       rready,
	output word_t      awaddr,
	output logic       awvalid,
	input  logic       awready,
	output word_t      wdata,
	output logic [3:0] wstrb,
	output logic       wvalid,
	input  logic       wready,
	input  resp_t      bresp,
	input  logic       bvalid,
	output logic       bready
);

	typedef enum logic [2:0] {ST_IDLE, ST_AR, ST_R, ST_W, ST_B} state_t;

	state_t     state;
	word_t      addr_q;
	word_t      wdata_q;
	logic [3:0] wstrb_q;
	logic       aw_pend;
	logic       w_pend;
	logic       aw_fire;
	logic       w_fire;

	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state   <= ST_IDLE;
			aw_pend <= 1'b0;
			w_pend  <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: if (req.start) begin
					if (req.write) begin
						state   <= ST_W;
						aw_pend <= 1'b1;
						w_pend  <= 1'b1;
					end else begin
						state <= ST_AR;
					end
				end
				ST_AR: if (arready) state <= ST_R;
				ST_R: if (rvalid) state <= ST_IDLE;
				ST_W: begin
					if (aw_fire) aw_pend <= 1'b0;
					if (w_fire) w_pend <= 1'b0;
					if ((aw_fire || !aw_pend) && (w_fire || !w_pend)) state <= ST_B;
				end
				ST_B: if (bvalid) state <= ST_IDLE;
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == ST_IDLE && req.start) begin
			addr_q  <= req.addr;
			wdata_q <= req.wdata;
			wstrb_q <= req.wstrb;
		end
	end

	assign araddr  = addr_q;
	assign arvalid = (state == ST_AR);
	assign rready  = (state == ST_R);
	assign awaddr  = addr_q;
	assign awvalid = (state == ST_W) && aw_pend;
	assign wdata   = wdata_q;
	assign wstrb   = wstrb_q;
	assign wvalid  = (state == ST_W) && w_pend;
	assign bready  = (state == ST_B);

	assign req.done  = (state == ST_R && rvalid) || (state == ST_B && bvalid);
	assign req.rdata = rdata;
	assign req.err   = (state == ST_R) ? (|rresp) : (|bresp); // any nonzero resp.

endmodule

//--- hw/mem_req_if.sv
interface mem_req_if
	import core_pkg::*;
();

	logic       start; // one-cycle pulse while idle.
	logic       write;
	word_t      addr;
	word_t      wdata;
	logic [3:0] wstrb;

	logic  done; // once per start.
	word_t rdata;
	logic  err;

	modport ctrl (
		output start, write, addr, wdata, wstrb,
		input  done, rdata, err
	);

	modport port (
		input  start, write, addr, wdata, wstrb,
		output done, rdata, err
	);

endinterface

//--- hw/regfile.sv
module regfile
	import core_pkg::*;
(
	input  logic     clock,
	input  logic     rst_n,
	input  reg_idx_t raddr1,
	input  reg_idx_t raddr2,
	output word_t    rdata1,
	output word_t    rdata2,
	input  logic     wen,
	input  reg_idx_t waddr,
	input  word_t    wdata
);

	word_t regs [2**$bits(reg_idx_t)];

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**$bits(reg_idx_t); i++) regs[i] <= '0;
		end else if (wen && waddr != '0) begin
			regs[waddr] <= wdata; // x0 never written.
		end
	end

	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- include/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// first fetch after reset.
`define RESET_PC 32'h3000_0000

// fetch address after a bus error.
`define TRAP_PC 32'h0000_0000

`define XLEN 32

`define REG_ADDR_W 4

`endif

//--- project.f
+incdir+include
hw/core_pkg.sv
hw/mem_req_if.sv
hw/regfile.sv
hw/idu.sv
hw/exu.sv
hw/mem_access.sv
hw/core_ctrl.sv
hw/core_top.sv
sim/tb_clock.sv
sim/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timing -Wno-fatal \
	--top-module tb_top -f project.f -o tb_sim \
	&& ./obj_dir/tb_sim | tee sim.log \
	&& grep -q "^TEST OK$" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

//--- sim/tb_clock.sv
module tb_clock (
	output logic clock,
	output logic rst_n
);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // period 20.
	end

	initial begin
		rst_n = 1'b0;
		repeat (5) @(posedge clock);
		rst_n <= 1'b1;
	end

endmodule

//--- sim/tb_top.sv
`include "core_cfg.svh"

module tb_top
	import core_pkg::*;
();

	localparam word_t DATA_BASE = 32'h3000_1000;
	localparam word_t ERR_ADDR  = DATA_BASE + 32'h100; // answered with a bus error.
	localparam int    PROG_LEN  = 33;
	localparam int    LIMIT     = 40 * PROG_LEN * 4;

	logic clock;
	logic rst_n;

	word_t      araddr;
	logic       arvalid;
	logic       arready = 1'b0;
	word_t      rdata   = '0;
	resp_t      rresp   = '0;
	logic       rvalid  = 1'b0;
	logic       rready;
	word_t      awaddr;
	logic       awvalid;
	logic       awready = 1'b0;
	word_t      wdata;
	logic [3:0] wstrb;
	logic       wvalid;
	logic       wready  = 1'b0;
	resp_t      bresp   = '0;
	logic       bvalid  = 1'b0;
	logic       bready;
	logic       retire;
	word_t      retire_pc;

	word_t prog [64];
	word_t trap_code [8];
	word_t data [64];
	word_t ref_data [64];
	word_t ref_x [16];
	word_t ref_pc = `RESET_PC;

	word_t aw_q [$];
	word_t w_q [$];
	word_t ld_q [$];
	word_t exp_fetch = `RESET_PC;
	logic  fetch_next = 1'b1;
	int    fetch_cnt = 0;
	int    retire_cnt = 0;
	int    cycles = 0;
	int    errors = 0;
	logic  finished = 1'b0;
	logic  timed_out = 1'b0;

	int unsigned ar_wait = 0;
	int unsigned r_wait = 0;
	int unsigned aw_wait = 0;
	int unsigned w_wait = 0;
	int unsigned b_wait = 0;
	word_t r_addr;
	word_t w_addr;
	word_t w_data;
	logic  r_pend = 1'b0;
	logic  aw_got = 1'b0;
	logic  w_got = 1'b0;

	tb_clock u_clock (.clock(clock), .rst_n(rst_n));

	core_top DUT (
		.clock(clock), .rst_n(rst_n),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.retire(retire), .retire_pc(retire_pc)
	);

	// ##################################################
	// instruction encoders
	// ##################################################
	function automatic word_t itype(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, 3'b000, rd, op} | ((op == 7'h03) ? 32'h2000 : 32'h0); // lw is funct3 2.
	endfunction

	function automatic word_t stype(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
	endfunction

	function automatic word_t btype(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'h63};
	endfunction

	function automatic word_t utype(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] op);
		return {imm, rd, op};
	endfunction

	function automatic word_t jtype(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
	endfunction

	function automatic word_t rtype(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [4:0] rs2);
		return {7'b0, rs2, rs1, 3'b000, rd, 7'h33};
	endfunction

	function automatic word_t fill_word(input word_t a);
		return a ^ {a[15:0], a[31:16]} ^ 32'h5a5a_c3c3;
	endfunction

	function automatic word_t code_word(input word_t a);
		if (a >= `RESET_PC && a < `RESET_PC + 32'h100) return prog[(a - `RESET_PC) >> 2];
		if (a >= `TRAP_PC && a < `TRAP_PC + 32'h20) return trap_code[(a - `TRAP_PC) >> 2];
		return '0;
	endfunction

	function automatic word_t read_word(input word_t a);
		if (a >= DATA_BASE && a < DATA_BASE + 32'h100) return data[(a - DATA_BASE) >> 2];
		return code_word(a);
	endfunction

	task automatic report_mismatch(input string name, input word_t got, input word_t exp);
		errors++;
		$display("FAIL t=%0t %s got=%h exp=%h", $time, name, got, exp);
	endtask

	task automatic note_error(input string msg);
		errors++;
		$display("ERROR t=%0t %s", $time, msg);
	endtask

	task automatic load_program;
		prog[0]  = utype(20'h30001, 5'd1, 7'h37);          // x1 = data base.
		prog[1]  = itype(12'd5, 5'd0, 5'd2, 7'h13);
		prog[2]  = itype(12'hff4, 5'd2, 5'd3, 7'h13);      // 5 - 12.
		prog[3]  = rtype(5'd4, 5'd2, 5'd3);
		prog[4]  = itype(12'd7, 5'd2, 5'd0, 7'h13);        // x0 stays zero.
		prog[5]  = utype(20'h00012, 5'd5, 7'h17);
		prog[6]  = stype(12'd0, 5'd2, 5'd1);
		prog[7]  = stype(12'd4, 5'd3, 5'd1);
		prog[8]  = stype(12'd8, 5'd4, 5'd1);
		prog[9]  = stype(12'd12, 5'd5, 5'd1);
		prog[10] = stype(12'd16, 5'd0, 5'd1);
		prog[11] = itype(12'd64, 5'd1, 5'd6, 7'h03);
		prog[12] = stype(12'd20, 5'd6, 5'd1);
		prog[13] = btype(13'd8, 5'd3, 5'd2);               // not taken.
		prog[14] = btype(13'd8, 5'd2, 5'd2);               // taken.
		prog[15] = itype(12'd1, 5'd0, 5'd7, 7'h13);
		prog[16] = jtype(21'd8, 5'd8);
		prog[17] = itype(12'd2, 5'd0, 5'd7, 7'h13);
		prog[18] = utype(20'h0, 5'd9, 7'h17);
		prog[19] = itype(12'd28, 5'd9, 5'd10, 7'h67);     // jalr to index 25.
		for (int i = 20; i < 25; i++) prog[i] = itype(12'd3, 5'd0, 5'd7, 7'h13);
		prog[25] = stype(12'd24, 5'd8, 5'd1);
		prog[26] = stype(12'd28, 5'd10, 5'd1);
		prog[27] = itype(12'd28, 5'd1, 5'd11, 7'h03);
		prog[28] = stype(12'd32, 5'd11, 5'd1);
		prog[29] = itype(12'd99, 5'd0, 5'd6, 7'h13);
		prog[30] = itype(12'h100, 5'd1, 5'd6, 7'h03);    // faulting load.
		for (int i = 31; i < 64; i++) prog[i] = '0;
		trap_code[0] = stype(12'd36, 5'd6, 5'd1);          // x6 must still be 99.
		trap_code[1] = jtype(21'd0, 5'd0);
		for (int i = 2; i < 8; i++) trap_code[i] = '0;
		for (int i = 0; i < 64; i++) begin
			data[i]     = fill_word(DATA_BASE + 4 * i);
			ref_data[i] = data[i];
		end
		for (int i = 0; i < 16; i++) ref_x[i] = '0;
	endtask

	// ##################################################
	// reference instruction model
	// ##################################################
	task automatic run_model;
		word_t ins;
		word_t a;
		word_t b;
		word_t ea;
		word_t nxt;
		word_t res;
		word_t got;
		logic [3:0] rd;
		logic wr;
		ins = code_word(ref_pc);
		rd  = ins[10:7];
		a   = ref_x[ins[18:15]];
		b   = ref_x[ins[23:20]];
		nxt = ref_pc + 4;
		wr  = 1'b1;
		res = '0;
		case (ins[6:0])
			7'h37: res = {ins[31:12], 12'b0};
			7'h17: res = ref_pc + {ins[31:12], 12'b0};
			7'h6f: begin
				res = ref_pc + 4;
				nxt = ref_pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			end
			7'h67: begin
				res = ref_pc + 4;
				nxt = (a + {{20{ins[31]}}, ins[31:20]}) & ~32'h1;
			end
			7'h63: begin
				wr = 1'b0;
				if (a == b) nxt = ref_pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
					ins[11:8], 1'b0};
			end
			7'h03: begin
				ea = a + {{20{ins[31]}}, ins[31:20]};
				if (ld_q.size() == 0) note_error("load retired without a read");
				else begin
					got = ld_q.pop_front();
					assert (got == ea) else report_mismatch("araddr", got, ea);
				end
				if (ea == ERR_ADDR) begin
					wr  = 1'b0;
					nxt = `TRAP_PC;
				end else begin
					res = ref_data[(ea - DATA_BASE) >> 2];
				end
			end
			7'h23: begin
				wr = 1'b0;
				ea = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				ref_data[(ea - DATA_BASE) >> 2] = b;
				if (aw_q.size() == 0 || w_q.size() == 0) begin
					note_error("store retired without a write");
				end else begin
					got = aw_q.pop_front();
					assert (got == ea) else report_mismatch("awaddr", got, ea);
					got = w_q.pop_front();
					assert (got == b) else report_mismatch("wdata", got, b);
				end
			end
			7'h13: res = a + {{20{ins[31]}}, ins[31:20]};
			7'h33: res = a + b;
			default: wr = 1'b0;
		endcase
		if (wr && rd != 0) ref_x[rd] = res;
		ref_pc = nxt;
	endtask

	// ##################################################
	// memory model
	// ##################################################
	always @(posedge clock) begin
		if (rst_n) begin
			if (arvalid && arready) begin
				arready <= 1'b0;
				ar_wait <= $urandom % 4;
				r_addr  <= araddr;
				r_pend  <= 1'b1;
				r_wait  <= $urandom % 4;
			end else if (arvalid) begin
				if (ar_wait == 0) arready <= 1'b1;
				else ar_wait <= ar_wait - 1;
			end
			if (rvalid && rready) begin
				rvalid <= 1'b0;
				r_pend <= 1'b0;
			end else if (r_pend && !rvalid) begin
				if (r_wait == 0) begin
					rvalid <= 1'b1;
					rdata  <= read_word(r_addr);
					rresp  <= (r_addr == ERR_ADDR) ? 2'b10 : 2'b00;
				end else begin
					r_wait <= r_wait - 1;
				end
			end
			if (awvalid && awready) begin
				awready <= 1'b0;
				aw_wait <= $urandom % 4;
				w_addr  <= awaddr;
				aw_got  <= 1'b1;
			end else if (awvalid) begin
				if (aw_wait == 0) awready <= 1'b1;
				else aw_wait <= aw_wait - 1;
			end
			if (wvalid && wready) begin
				wready <= 1'b0;
				w_wait <= $urandom % 4;
				w_data <= wdata;
				w_got  <= 1'b1;
			end else if (wvalid) begin
				if (w_wait == 0) wready <= 1'b1;
				else w_wait <= w_wait - 1;
			end
			if (bvalid && bready) begin
				bvalid <= 1'b0;
				aw_got <= 1'b0;
				w_got  <= 1'b0;
			end else if (aw_got && w_got && !bvalid) begin
				if (b_wait == 0) begin
					bvalid <= 1'b1;
					bresp  <= 2'b00;
					b_wait <= $urandom % 4;
					if (w_addr >= DATA_BASE && w_addr < DATA_BASE + 32'h100)
						data[(w_addr - DATA_BASE) >> 2] = w_data;
				end else begin
					b_wait <= b_wait - 1;
				end
			end
		end
	end

	// handshake monitor and model step.
	always @(posedge clock) begin
		cycles++;
		if (cycles >= LIMIT) timed_out = 1'b1;
		if (rst_n) begin
			if (arvalid && arready) begin
				if (fetch_next) begin
					assert (araddr == exp_fetch) else report_mismatch("araddr", araddr, exp_fetch);
					fetch_next = 1'b0;
					fetch_cnt++;
				end else begin
					ld_q.push_back(araddr);
				end
			end
			if (awvalid && awready) aw_q.push_back(awaddr);
			if (wvalid && wready) w_q.push_back(wdata);
			if (retire) begin
				run_model();
				retire_cnt++;
				exp_fetch  = ref_pc;
				fetch_next = 1'b1;
				if (ref_pc == `TRAP_PC + 4) finished = 1'b1; // trap store done.
			end
		end
	end

	// ##################################################
	// channel and retire checks
	// ##################################################
	assert property (@(posedge clock) !rst_n |->
		!(arvalid || awvalid || wvalid || rready || bready || retire))
		else note_error("bus or retire output active during reset");
	assert property (@(posedge clock) disable iff (!rst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else note_error("ar dropped or changed before arready");
	assert property (@(posedge clock) disable iff (!rst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else note_error("aw dropped or changed before awready");
	assert property (@(posedge clock) disable iff (!rst_n)
		wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
		else note_error("w dropped or changed before wready");
	assert property (@(posedge clock) disable iff (!rst_n)
		wvalid |-> wstrb == 4'hf)
		else report_mismatch("wstrb", {28'b0, $sampled(wstrb)}, 32'hf);
	assert property (@(posedge clock) disable iff (!rst_n)
		arvalid |-> !(awvalid || wvalid || bready))
		else note_error("read issued while a write is outstanding");
	assert property (@(posedge clock) disable iff (!rst_n)
		retire |-> retire_pc == ref_pc)
		else report_mismatch("retire_pc", $sampled(retire_pc), $sampled(ref_pc));
	assert property (@(posedge clock) disable iff (!rst_n)
		retire |-> fetch_cnt == retire_cnt + 1)
		else note_error("retire count does not match fetch count");

	initial begin
		void'($urandom(32'hcf21bf15));
		load_program();
		@(posedge rst_n);
		@(negedge clock);
		assert (!(arvalid || awvalid || wvalid || rready || bready || retire))
			else note_error("output active right after reset release");
		wait (finished || timed_out);
		@(posedge clock);
		if (timed_out) note_error("timeout before the program finished");
		if (aw_q.size() != 0 || w_q.size() != 0 || ld_q.size() != 0)
			note_error("bus transfers left without a retire");
		$display("checks done, %0d retired, %0d errors", retire_cnt, errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
